//--- compile.f
source/clic_priv_pkg.sv
source/clic_csr_pkg.sv
source/clic_csr_file.sv
source/clic_source_arbiter.sv
source/clic_irq_controller.sv
source/clic_top.sv
tb/clic_tb.sv

//--- run.sh
#!/bin/sh
# Build the CLIC testbench with Verilator and run it, exit status is the verdict
cd "$(dirname "$0")" &&
  verilator --binary --timing -f compile.f --top-module clic_tb -o clic_sim &&
  ./obj_dir/clic_sim || exit 1

//--- tb/clic_tb.sv
/*
 * Testbench for the CLIC subsystem.
 * Shadows every configuration write, predicts request and cause with a
 * reference function and compares them in a separate process each clock.
 */
`timescale 1ns/1ps
`default_nettype none

module clic_tb
  import clic_priv_pkg::*;
  import clic_csr_pkg::*;
();

  localparam int unsigned NUM_SRC = 8;
  localparam int unsigned XLEN    = 32;
  localparam int unsigned IDX_W   = $clog2(NUM_SRC);

  // DUT ports
  logic               clk, rst;
  logic [NUM_SRC-1:0] irq_pending;
  priv_lvl_e          priv_lvl;
  logic               sie;
  logic               cfg_we;
  csr_addr_e          cfg_addr;
  logic [IDX_W-1:0]   cfg_src;
  logic [LEVEL_W-1:0] cfg_wdata, cfg_rdata;
  logic               irq_ready, kill_req, flush;
  logic               irq_req, kill_ack;
  logic [XLEN-1:0]    irq_cause;

  // Shadow of the configuration
  logic               sh_ie    [NUM_SRC];
  logic [LEVEL_W-1:0] sh_level [NUM_SRC];
  priv_lvl_e          sh_priv  [NUM_SRC];
  logic [LEVEL_W-1:0] sh_mth, sh_sth, sh_mil, sh_sil;

  logic               chk_en;        // Compare process active
  string              chk_name;
  logic [NUM_SRC-1:0] pend_q;        // Pending as the arbiter register saw it
  int                 n_checks = 0;
  integer             seed;
  logic [31:0]        rnd;

  clic_top #(.NUM_SRC(NUM_SRC), .XLEN(XLEN)) i_dut (
    .clk_i(clk), .rst_i(rst), .irq_pending_i(irq_pending),
    .priv_lvl_i(priv_lvl), .sie_i(sie),
    .cfg_we_i(cfg_we), .cfg_addr_i(cfg_addr), .cfg_src_i(cfg_src), .cfg_wdata_i(cfg_wdata),
    .cfg_rdata_o(cfg_rdata),
    .irq_ready_i(irq_ready), .kill_req_i(kill_req), .flush_i(flush),
    .irq_req_o(irq_req), .irq_cause_o(irq_cause), .kill_ack_o(kill_ack)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  // ------------------------------------------------------------
  // Reference model and compare tasks
  // ------------------------------------------------------------
  function automatic logic exp_accept(input logic [NUM_SRC-1:0] pend, input priv_lvl_e pl,
                                      input logic s, output logic [XLEN-1:0] cause);
    logic               any;
    int                 best;
    int                 i;
    logic [LEVEL_W-1:0] m_thr, s_thr, lvl;
    any  = 1'b0;
    best = 0;
    for (i = 0; i < NUM_SRC; i++) begin
      if (pend[i] && sh_ie[i] && (!any || sh_level[i] > sh_level[best])) begin
        any  = 1'b1;  // Strictly higher only, lowest index wins ties
        best = i;
      end
    end
    lvl   = sh_level[best];
    m_thr = (sh_mth > sh_mil) ? sh_mth : sh_mil;
    s_thr = (sh_sth > sh_sil) ? sh_sth : sh_sil;
    cause         = '0;
    cause[XLEN-1] = 1'b1;        // Interrupt flag
    cause[23:16]  = lvl;
    cause[15:0]   = 16'(best);
    if (!any) return 1'b0;
    case (pl)
      PRIV_M:  return (sh_priv[best] == PRIV_M) && (lvl > m_thr);
      PRIV_S:  return (sh_priv[best] == PRIV_M) ||
                      ((sh_priv[best] == PRIV_S) && s && (lvl > s_thr));
      default: return 1'b1;     // User mode takes anything valid
    endcase
  endfunction

  task automatic halt_run();
    $display(">>> FAIL");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %b actual %b", name, exp, act);
      halt_run();
    end
  endtask

  task automatic check_cause(input string name, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      halt_run();
    end
  endtask

  task automatic check_data(input string name, input logic [LEVEL_W-1:0] exp,
                            input logic [LEVEL_W-1:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      halt_run();
    end
  endtask

  // Samples just before the edge, where all outputs are settled
  always @(posedge clk) begin : compare_proc
    logic            exp_req;
    logic [XLEN-1:0] exp_cause;
    if (chk_en) begin
      exp_req = exp_accept(pend_q, priv_lvl, sie, exp_cause);
      check_bit(chk_name, exp_req, irq_req);
      if (exp_req) check_cause(chk_name, exp_cause, irq_cause);
      n_checks++;
    end
    pend_q <= irq_pending;
  end

  // ------------------------------------------------------------
  // Stimulus helpers, all start on a falling edge
  // ------------------------------------------------------------
  function automatic logic [LEVEL_W-1:0] priv_code(input logic [1:0] r);
    return (r[1]) ? LEVEL_W'(PRIV_M) : LEVEL_W'(r);  // 0 U, 1 S, 2 and 3 M
  endfunction

  task automatic cfg_write(input csr_addr_e addr, input logic [IDX_W-1:0] src,
                           input logic [LEVEL_W-1:0] data);
    @(negedge clk);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_src   = src;
    cfg_wdata = data;
    @(negedge clk);
    cfg_we = 1'b0;
    case (addr)
      CSR_MINTTHRESH: sh_mth = data;
      CSR_SINTTHRESH: sh_sth = data;
      CSR_MIL:        sh_mil = data;
      CSR_SIL:        sh_sil = data;
      CSR_SRC_IE:     sh_ie[src] = data[0];
      CSR_SRC_LEVEL:  sh_level[src] = data;
      default:        sh_priv[src] = priv_lvl_e'(data[1:0]);
    endcase
  endtask

  task automatic read_check(input string name, input csr_addr_e addr,
                            input logic [IDX_W-1:0] src);
    logic [LEVEL_W-1:0] exp;
    @(negedge clk);
    cfg_addr = addr;
    cfg_src  = src;
    #1;  // Read port is combinational
    case (addr)
      CSR_MINTTHRESH: exp = sh_mth;
      CSR_SINTTHRESH: exp = sh_sth;
      CSR_MIL:        exp = sh_mil;
      CSR_SIL:        exp = sh_sil;
      CSR_SRC_IE:     exp = {{(LEVEL_W-1){1'b0}}, sh_ie[src]};
      CSR_SRC_LEVEL:  exp = sh_level[src];
      default:        exp = {{(LEVEL_W-2){1'b0}}, sh_priv[src]};
    endcase
    check_data(name, exp, cfg_rdata);
  endtask

  // Settle one cycle after config writes, then compare for a while
  task automatic run_checked(input string name, input int cycles);
    @(negedge clk);
    chk_name = name;
    chk_en   = 1'b1;
    repeat (cycles) @(negedge clk);
    chk_en = 1'b0;
  endtask

  task automatic wait_req(input string name);
    int n;
    n = 0;
    while (irq_req !== 1'b1 && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (irq_req !== 1'b1) begin
      $display("Timeout in %s, irq_req_o not raised within 20 cycles", name);
      halt_run();
    end
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin : main_seq
    int i, a, b, s;
    seed        = 49154;
    rst         = 1'b1;
    irq_pending = '0;
    priv_lvl    = PRIV_U;
    sie         = 1'b0;
    cfg_we      = 1'b0;
    cfg_addr    = CSR_MINTTHRESH;
    cfg_src     = '0;
    cfg_wdata   = '0;
    irq_ready   = 1'b0;
    kill_req    = 1'b0;
    flush       = 1'b0;
    chk_en      = 1'b0;
    chk_name    = "idle";
    {sh_mth, sh_sth, sh_mil, sh_sil} = '0;
    for (i = 0; i < NUM_SRC; i++) begin
      sh_ie[i]    = 1'b0;
      sh_level[i] = '0;
      sh_priv[i]  = PRIV_U;
    end
    repeat (16) @(negedge clk);
    rst = 1'b0;

    // Reset state and read-back of every address
    @(negedge clk);
    check_bit("reset_req", 1'b0, irq_req);
    check_bit("reset_kill_ack", 1'b0, kill_ack);
    cfg_write(CSR_MINTTHRESH, '0, 8'h11);
    cfg_write(CSR_SINTTHRESH, '0, 8'h22);
    cfg_write(CSR_MIL, '0, 8'h33);
    cfg_write(CSR_SIL, '0, 8'h44);
    for (i = 0; i < NUM_SRC; i++) begin
      rnd = $random(seed);
      cfg_write(CSR_SRC_IE, IDX_W'(i), rnd[7:0]);
      cfg_write(CSR_SRC_LEVEL, IDX_W'(i), rnd[15:8]);
      cfg_write(CSR_SRC_PRIV, IDX_W'(i), priv_code(rnd[17:16]));
    end
    read_check("readback_mth", CSR_MINTTHRESH, '0);
    read_check("readback_sth", CSR_SINTTHRESH, '0);
    read_check("readback_mil", CSR_MIL, '0);
    read_check("readback_sil", CSR_SIL, '0);
    for (i = 0; i < NUM_SRC; i++) begin
      read_check("readback_ie", CSR_SRC_IE, IDX_W'(i));
      read_check("readback_level", CSR_SRC_LEVEL, IDX_W'(i));
      read_check("readback_priv", CSR_SRC_PRIV, IDX_W'(i));
    end
    cfg_write(CSR_MINTTHRESH, '0, 8'h00);
    cfg_write(CSR_SINTTHRESH, '0, 8'h00);
    cfg_write(CSR_MIL, '0, 8'h00);
    cfg_write(CSR_SIL, '0, 8'h00);

    // Arbitration in user mode, small levels give frequent ties
    for (a = 0; a < 4; a++) begin
      for (i = 0; i < NUM_SRC; i++) begin
        rnd = $random(seed);
        cfg_write(CSR_SRC_IE, IDX_W'(i), LEVEL_W'(rnd[1:0] != 2'b00));
        cfg_write(CSR_SRC_LEVEL, IDX_W'(i), LEVEL_W'(rnd[4:2]));
        cfg_write(CSR_SRC_PRIV, IDX_W'(i), priv_code(rnd[6:5]));
      end
      @(negedge clk);
      chk_name = "arbitration";
      chk_en   = 1'b1;
      repeat (12) begin
        @(negedge clk);
        rnd         = $random(seed);
        irq_pending = rnd[NUM_SRC-1:0];
      end
      repeat (2) @(negedge clk);  // Last vector through the register
      chk_en = 1'b0;
    end

    // Machine mode threshold sweep, single source at level 100
    irq_pending = '0;
    priv_lvl    = PRIV_M;
    for (i = 0; i < NUM_SRC; i++) cfg_write(CSR_SRC_IE, IDX_W'(i), LEVEL_W'(i == 0));
    cfg_write(CSR_SRC_LEVEL, '0, 8'd100);
    cfg_write(CSR_SRC_PRIV, '0, LEVEL_W'(PRIV_M));
    irq_pending = 8'h01;
    for (a = 0; a < 4; a++) begin
      for (b = 0; b < 4; b++) begin
        cfg_write(CSR_MINTTHRESH, '0, LEVEL_W'(a * 50));
        cfg_write(CSR_MIL, '0, LEVEL_W'(b * 50));
        run_checked("thresh_m", 2);
      end
    end
    cfg_write(CSR_SRC_PRIV, '0, LEVEL_W'(PRIV_S));
    cfg_write(CSR_MINTTHRESH, '0, 8'h00);
    cfg_write(CSR_MIL, '0, 8'h00);
    run_checked("thresh_m_s_source", 3);  // S source never taken in M

    // Supervisor mode, M source preempts regardless of thresholds
    priv_lvl = PRIV_S;
    cfg_write(CSR_SRC_PRIV, '0, LEVEL_W'(PRIV_M));
    cfg_write(CSR_MINTTHRESH, '0, 8'd200);
    cfg_write(CSR_SINTTHRESH, '0, 8'd200);
    run_checked("thresh_s_m_source", 2);
    cfg_write(CSR_SRC_PRIV, '0, LEVEL_W'(PRIV_S));
    for (s = 0; s < 2; s++) begin
      sie = (s != 0);
      for (a = 0; a < 4; a++) begin
        for (b = 0; b < 4; b++) begin
          cfg_write(CSR_SINTTHRESH, '0, LEVEL_W'(a * 50));
          cfg_write(CSR_SIL, '0, LEVEL_W'(b * 50));
          run_checked("thresh_s", 2);
        end
      end
    end
    cfg_write(CSR_MINTTHRESH, '0, 8'h00);
    cfg_write(CSR_SINTTHRESH, '0, 8'h00);
    cfg_write(CSR_SIL, '0, 8'h00);

    // Acknowledge loads mil, then sil
    irq_pending = '0;
    priv_lvl    = PRIV_U;
    for (i = 0; i < NUM_SRC; i++) cfg_write(CSR_SRC_IE, IDX_W'(i), LEVEL_W'(i == 2));
    cfg_write(CSR_SRC_LEVEL, 3'd2, 8'h5A);
    cfg_write(CSR_SRC_PRIV, 3'd2, LEVEL_W'(PRIV_M));
    irq_pending = 8'h04;
    wait_req("ack_mil");
    irq_ready = 1'b1;
    @(negedge clk);
    irq_ready = 1'b0;
    sh_mil    = 8'h5A;
    read_check("ack_mil", CSR_MIL, '0);
    irq_pending = '0;
    cfg_write(CSR_SRC_LEVEL, 3'd2, 8'h33);
    cfg_write(CSR_SRC_PRIV, 3'd2, LEVEL_W'(PRIV_S));
    irq_pending = 8'h04;
    wait_req("ack_sil");
    irq_ready = 1'b1;
    @(negedge clk);
    irq_ready = 1'b0;
    sh_sil    = 8'h33;
    read_check("ack_sil", CSR_SIL, '0);
    read_check("ack_mil_kept", CSR_MIL, '0);

    // Kill control
    @(negedge clk);
    irq_pending = '0;
    flush       = 1'b1;   // Drop whatever is in flight
    @(negedge clk);
    flush    = 1'b0;
    kill_req = 1'b1;
    #1;
    check_bit("kill_idle", 1'b1, kill_ack);
    @(negedge clk);
    kill_req    = 1'b0;
    irq_pending = 8'h04;
    wait_req("kill_raise");
    irq_pending = '0;     // Source drops without acknowledge
    @(negedge clk);
    kill_req = 1'b1;
    #1;
    check_bit("kill_held", 1'b0, kill_ack);
    @(negedge clk);
    irq_ready = 1'b1;
    @(negedge clk);
    irq_ready = 1'b0;
    #1;
    check_bit("kill_after_ready", 1'b1, kill_ack);
    @(negedge clk);
    kill_req    = 1'b0;
    irq_pending = 8'h04;
    wait_req("kill_raise_again");
    irq_pending = '0;
    @(negedge clk);
    kill_req = 1'b1;
    #1;
    check_bit("kill_held_again", 1'b0, kill_ack);
    @(negedge clk);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    #1;
    check_bit("kill_after_flush", 1'b1, kill_ack);
    @(negedge clk);
    kill_req = 1'b0;
    #1;
    check_bit("kill_release", 1'b0, kill_ack);

    if (n_checks > 100) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("Compare process ran only %0d checks", n_checks);
      halt_run();
    end
  end

endmodule

`default_nettype wire

//--- source/clic_top.sv
/*
 * Top level of the CLIC subsystem.
 * Connects the CSR file, the source arbiter and the interrupt controller.
 */
`timescale 1ns/1ps
`default_nettype none

module clic_top
  import clic_priv_pkg::*;
  import clic_csr_pkg::*;
#(
  parameter  int unsigned NUM_SRC = 8,
  parameter  int unsigned XLEN    = 32,
  localparam int unsigned IDX_W   = $clog2(NUM_SRC)
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic [NUM_SRC-1:0] irq_pending_i,
  // Core state
  input  priv_lvl_e          priv_lvl_i,
  input  logic               sie_i,
  // Configuration port
  input  logic               cfg_we_i,
  input  csr_addr_e          cfg_addr_i,
  input  logic [IDX_W-1:0]   cfg_src_i,
  input  logic [LEVEL_W-1:0] cfg_wdata_i,
  output logic [LEVEL_W-1:0] cfg_rdata_o,
  // Core side
  input  logic               irq_ready_i,
  input  logic               kill_req_i,
  input  logic               flush_i,
  output logic               irq_req_o,
  output logic [XLEN-1:0]    irq_cause_o,
  output logic               kill_ack_o
);

  // CSR file to controller
  logic [LEVEL_W-1:0] mintthresh, sintthresh, mil, sil;
  // CSR file to arbiter
  logic               src_ie_we, src_level_we, src_priv_we;
  logic [IDX_W-1:0]   src_idx;
  logic [LEVEL_W-1:0] src_wdata;
  logic               src_ie_rd;
  logic [LEVEL_W-1:0] src_level_rd;
  priv_lvl_e          src_priv_rd;
  // Arbiter to controller
  logic               irq_valid;
  logic [IDX_W-1:0]   irq_id;
  logic [LEVEL_W-1:0] irq_level;
  priv_lvl_e          irq_priv;

  clic_csr_file #(.NUM_SRC(NUM_SRC)) i_csr_file (
    .clk_i, .rst_i,
    .cfg_we_i, .cfg_addr_i, .cfg_src_i, .cfg_wdata_i,
    .src_ie_rd_i(src_ie_rd), .src_level_rd_i(src_level_rd), .src_priv_rd_i(src_priv_rd),
    .ack_i(irq_req_o), .ack_ready_i(irq_ready_i),  // Handshake qualified inside
    .ack_priv_i(irq_priv), .ack_level_i(irq_level),
    .mintthresh_o(mintthresh), .sintthresh_o(sintthresh), .mil_o(mil), .sil_o(sil),
    .src_ie_we_o(src_ie_we), .src_level_we_o(src_level_we), .src_priv_we_o(src_priv_we),
    .src_idx_o(src_idx), .src_wdata_o(src_wdata),
    .cfg_rdata_o
  );

  clic_source_arbiter #(.NUM_SRC(NUM_SRC)) i_arbiter (
    .clk_i, .rst_i,
    .pending_i(irq_pending_i),
    .ie_we_i(src_ie_we), .level_we_i(src_level_we), .priv_we_i(src_priv_we),
    .idx_i(src_idx), .wdata_i(src_wdata),
    .rd_idx_i(cfg_src_i),  // Read index straight from the port
    .rd_ie_o(src_ie_rd), .rd_level_o(src_level_rd), .rd_priv_o(src_priv_rd),
    .irq_valid_o(irq_valid), .irq_id_o(irq_id), .irq_level_o(irq_level), .irq_priv_o(irq_priv)
  );

  clic_irq_controller #(.NUM_SRC(NUM_SRC), .XLEN(XLEN)) i_controller (
    .clk_i, .rst_i,
    .clear_i(flush_i),
    .priv_lvl_i, .sie_i,
    .mintthresh_i(mintthresh), .sintthresh_i(sintthresh), .mil_i(mil), .sil_i(sil),
    .irq_valid_i(irq_valid), .irq_ready_i,
    .irq_id_i(irq_id), .irq_level_i(irq_level), .irq_priv_i(irq_priv),
    .kill_req_i, .kill_ack_o,
    .irq_req_o, .irq_cause_o
  );

endmodule

`default_nettype wire

//--- source/clic_irq_controller.sv
/*
 * CLIC interrupt controller.
 * Gates the selected interrupt against the effective threshold of the
 * current privilege level, packs the cause word and holds kill requests
 * off while an accepted interrupt is still in flight.
 */
`timescale 1ns/1ps
`default_nettype none

module clic_irq_controller
  import clic_priv_pkg::*;
#(
  parameter  int unsigned NUM_SRC = 8,
  parameter  int unsigned XLEN    = 32,
  localparam int unsigned IDX_W   = $clog2(NUM_SRC)
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               clear_i,       // Pipeline flush
  // Core state
  input  priv_lvl_e          priv_lvl_i,
  input  logic               sie_i,
  // Thresholds and status from the CSR file
  input  logic [LEVEL_W-1:0] mintthresh_i,
  input  logic [LEVEL_W-1:0] sintthresh_i,
  input  logic [LEVEL_W-1:0] mil_i,
  input  logic [LEVEL_W-1:0] sil_i,
  // Selected interrupt
  input  logic               irq_valid_i,
  input  logic               irq_ready_i,   // Core acknowledge
  input  logic [IDX_W-1:0]   irq_id_i,
  input  logic [LEVEL_W-1:0] irq_level_i,
  input  priv_lvl_e          irq_priv_i,
  input  logic               kill_req_i,
  output logic               kill_ack_o,
  output logic               irq_req_o,
  output logic [XLEN-1:0]    irq_cause_o
);

  // ------------------------------------------------------------
  // Trigger
  // ------------------------------------------------------------
  logic [LEVEL_W-1:0] eff_mthresh;  // max(mintthresh, mil)
  logic [LEVEL_W-1:0] eff_sthresh;  // max(sintthresh, sil)

  assign eff_mthresh = (mintthresh_i > mil_i) ? mintthresh_i : mil_i;
  assign eff_sthresh = (sintthresh_i > sil_i) ? sintthresh_i : sil_i;

  always_comb begin
    irq_req_o = 1'b0;
    case (priv_lvl_i)
      PRIV_M: begin  // Only higher M-level interrupts
        irq_req_o = irq_valid_i && (irq_priv_i == PRIV_M) && (irq_level_i > eff_mthresh);
      end
      PRIV_S: begin
        if (irq_priv_i == PRIV_M) begin
          irq_req_o = irq_valid_i;  // M always preempts S
        end else if (irq_priv_i == PRIV_S) begin
          irq_req_o = irq_valid_i && sie_i && (irq_level_i > eff_sthresh);
        end
      end
      PRIV_U:  irq_req_o = irq_valid_i;  // Everything valid
      default: irq_req_o = 1'b0;
    endcase
  end

  // Cause word, top bit marks an interrupt
  always_comb begin
    irq_cause_o                                = '0;
    irq_cause_o[XLEN-1]                        = 1'b1;
    irq_cause_o[CAUSE_LEVEL_LSB +: LEVEL_W]    = irq_level_i;
    irq_cause_o[CAUSE_ID_W-1:0]                = CAUSE_ID_W'(irq_id_i);  // Zero-extended
  end

  // ------------------------------------------------------------
  // Kill control
  // ------------------------------------------------------------
  logic inflight_q;
  logic inflight_d;

  // Set on accept, drop on acknowledge or granted kill
  assign inflight_d = inflight_q ? ~(irq_ready_i | kill_ack_o) : irq_req_o;
  // Grant only when nothing is in flight or being accepted
  assign kill_ack_o = kill_req_i & ~inflight_q & ~irq_req_o;

  always_ff @(posedge clk_i) begin
    if (rst_i || clear_i) inflight_q <= 1'b0;
    else                  inflight_q <= inflight_d;
  end

endmodule

`default_nettype wire

//--- source/clic_source_arbiter.sv
/*
 * Per-source configuration and highest-level selection.
 * Scans all enabled pending sources each cycle and registers the
 * winner for the interrupt controller. Ties go to the lowest index.
 */
`timescale 1ns/1ps
`default_nettype none

module clic_source_arbiter
  import clic_priv_pkg::*;
#(
  parameter  int unsigned NUM_SRC = 8,
  localparam int unsigned IDX_W   = $clog2(NUM_SRC)
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic [NUM_SRC-1:0] pending_i,   // Level-sensitive lines
  // Configuration writes from the CSR file
  input  logic               ie_we_i,
  input  logic               level_we_i,
  input  logic               priv_we_i,
  input  logic [IDX_W-1:0]   idx_i,
  input  logic [LEVEL_W-1:0] wdata_i,
  // Configuration read-back
  input  logic [IDX_W-1:0]   rd_idx_i,
  output logic               rd_ie_o,
  output logic [LEVEL_W-1:0] rd_level_o,
  output priv_lvl_e          rd_priv_o,
  // Selected interrupt, registered
  output logic               irq_valid_o,
  output logic [IDX_W-1:0]   irq_id_o,
  output logic [LEVEL_W-1:0] irq_level_o,
  output priv_lvl_e          irq_priv_o
);

  // Per-source configuration
  logic               ie_q    [NUM_SRC];
  logic [LEVEL_W-1:0] level_q [NUM_SRC];
  priv_lvl_e          priv_q  [NUM_SRC];

  // Scan result
  logic               found;
  logic [IDX_W-1:0]   best_id;
  logic [LEVEL_W-1:0] best_level;
  priv_lvl_e          best_priv;

  // ------------------------------------------------------------
  // Configuration storage
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int unsigned i = 0; i < NUM_SRC; i++) begin
        ie_q[i]    <= 1'b0;
        level_q[i] <= '0;
        priv_q[i]  <= PRIV_U;
      end
    end else begin
      if (ie_we_i)    ie_q[idx_i]    <= wdata_i[0];
      if (level_we_i) level_q[idx_i] <= wdata_i;
      if (priv_we_i)  priv_q[idx_i]  <= priv_lvl_e'(wdata_i[1:0]);  // Code kept as written
    end
  end

  assign rd_ie_o    = ie_q[rd_idx_i];
  assign rd_level_o = level_q[rd_idx_i];
  assign rd_priv_o  = priv_q[rd_idx_i];

  // ------------------------------------------------------------
  // Highest-level scan
  // ------------------------------------------------------------
  always_comb begin
    found      = 1'b0;
    best_id    = '0;
    best_level = '0;
    best_priv  = PRIV_U;
    for (int unsigned i = 0; i < NUM_SRC; i++) begin
      // Strictly greater keeps the lower index on a tie
      if (pending_i[i] && ie_q[i] && (!found || (level_q[i] > best_level))) begin
        found      = 1'b1;
        best_id    = IDX_W'(i);
        best_level = level_q[i];
        best_priv  = priv_q[i];
      end
    end
  end

  // Winner register, one edge of latency
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      irq_valid_o <= 1'b0;
      irq_id_o    <= '0;
      irq_level_o <= '0;
      irq_priv_o  <= PRIV_U;
    end else begin
      irq_valid_o <= found;       // Any candidate
      irq_id_o    <= best_id;
      irq_level_o <= best_level;
      irq_priv_o  <= best_priv;
    end
  end

endmodule

`default_nettype wire

//--- source/clic_csr_file.sv
/*
 * Threshold and interrupt-status registers of the CLIC.
 * Decodes the configuration write port, forwards source writes to the
 * arbiter as strobes and serves the combinational read port.
 */
`timescale 1ns/1ps
`default_nettype none

module clic_csr_file
  import clic_priv_pkg::*;
  import clic_csr_pkg::*;
#(
  parameter  int unsigned NUM_SRC = 8,
  localparam int unsigned IDX_W   = $clog2(NUM_SRC)
) (
  input  logic               clk_i,
  input  logic               rst_i,
  // Configuration port
  input  logic               cfg_we_i,
  input  csr_addr_e          cfg_addr_i,
  input  logic [IDX_W-1:0]   cfg_src_i,
  input  logic [LEVEL_W-1:0] cfg_wdata_i,
  // Source fields read back from the arbiter
  input  logic               src_ie_rd_i,
  input  logic [LEVEL_W-1:0] src_level_rd_i,
  input  priv_lvl_e          src_priv_rd_i,
  // Interrupt acknowledge
  input  logic               ack_i,        // Request from the controller
  input  logic               ack_ready_i,  // Ready from the core
  input  priv_lvl_e          ack_priv_i,
  input  logic [LEVEL_W-1:0] ack_level_i,
  // Thresholds and status to the controller
  output logic [LEVEL_W-1:0] mintthresh_o,
  output logic [LEVEL_W-1:0] sintthresh_o,
  output logic [LEVEL_W-1:0] mil_o,
  output logic [LEVEL_W-1:0] sil_o,
  // Source configuration writes to the arbiter
  output logic               src_ie_we_o,
  output logic               src_level_we_o,
  output logic               src_priv_we_o,
  output logic [IDX_W-1:0]   src_idx_o,
  output logic [LEVEL_W-1:0] src_wdata_o,
  output logic [LEVEL_W-1:0] cfg_rdata_o
);

  logic ack_fire;       // Handshake completes this cycle
  logic wr_mth, wr_sth; // Threshold write strobes
  logic wr_mil, wr_sil; // Status write strobes

  assign ack_fire = ack_i & ack_ready_i;
  assign wr_mth   = cfg_we_i && (cfg_addr_i == CSR_MINTTHRESH);
  assign wr_sth   = cfg_we_i && (cfg_addr_i == CSR_SINTTHRESH);
  assign wr_mil   = cfg_we_i && (cfg_addr_i == CSR_MIL);
  assign wr_sil   = cfg_we_i && (cfg_addr_i == CSR_SIL);

  // ------------------------------------------------------------
  // Registers
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mintthresh_o <= '0;
      sintthresh_o <= '0;
      mil_o        <= '0;
      sil_o        <= '0;
    end else begin
      if (wr_mth) mintthresh_o <= cfg_wdata_i;
      if (wr_sth) sintthresh_o <= cfg_wdata_i;
      // Acknowledge wins over a CSR write in the same cycle
      if (ack_fire && (ack_priv_i == PRIV_M)) mil_o <= ack_level_i;
      else if (wr_mil)                        mil_o <= cfg_wdata_i;
      if (ack_fire && (ack_priv_i != PRIV_M)) sil_o <= ack_level_i;
      else if (wr_sil)                        sil_o <= cfg_wdata_i;
    end
  end

  // Source writes, applied by the arbiter on the same edge
  assign src_ie_we_o    = cfg_we_i && (cfg_addr_i == CSR_SRC_IE);
  assign src_level_we_o = cfg_we_i && (cfg_addr_i == CSR_SRC_LEVEL);
  assign src_priv_we_o  = cfg_we_i && (cfg_addr_i == CSR_SRC_PRIV);
  assign src_idx_o      = cfg_src_i;
  assign src_wdata_o    = cfg_wdata_i;

  // ------------------------------------------------------------
  // Read mux
  // ------------------------------------------------------------
  always_comb begin
    case (cfg_addr_i)
      CSR_MINTTHRESH: cfg_rdata_o = mintthresh_o;
      CSR_SINTTHRESH: cfg_rdata_o = sintthresh_o;
      CSR_MIL:        cfg_rdata_o = mil_o;
      CSR_SIL:        cfg_rdata_o = sil_o;
      CSR_SRC_IE:     cfg_rdata_o = {{(LEVEL_W-1){1'b0}}, src_ie_rd_i};
      CSR_SRC_LEVEL:  cfg_rdata_o = src_level_rd_i;
      CSR_SRC_PRIV:   cfg_rdata_o = {{(LEVEL_W-2){1'b0}}, src_priv_rd_i};  // Raw 2-bit code
      default:        cfg_rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- source/clic_csr_pkg.sv
/*
 * Address map of the CLIC configuration port.
 * Used for both the write strobe decode and the read mux.
 */
`default_nettype none

package clic_csr_pkg;

  // Configuration addresses
  typedef enum logic [2:0] {
    CSR_MINTTHRESH = 3'd0,  // M-mode threshold
    CSR_SINTTHRESH = 3'd1,  // S-mode threshold
    CSR_MIL        = 3'd2,  // mintstatus.mil
    CSR_SIL        = 3'd3,  // mintstatus.sil
    // Per-source fields, indexed by the source number
    CSR_SRC_IE     = 3'd4,
    CSR_SRC_LEVEL  = 3'd5,
    CSR_SRC_PRIV   = 3'd6
  } csr_addr_e;

endpackage

`default_nettype wire

//--- source/clic_priv_pkg.sv
/*
 * Privilege encoding and cause-word layout for the CLIC subsystem.
 * Imported by the top, the arbiter, the controller and the CSR file.
 */
`default_nettype none

package clic_priv_pkg;

  // ------------------------------------------------------------
  // Privilege levels
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    PRIV_U = 2'd0,  // User
    PRIV_S = 2'd1,  // Supervisor
    PRIV_M = 2'd3   // Machine, 2'd2 is reserved
  } priv_lvl_e;

  // Interrupt level width, also the CSR data width
  localparam int unsigned LEVEL_W = 8;

  // ------------------------------------------------------------
  // Cause word layout
  // ------------------------------------------------------------
  localparam int unsigned CAUSE_ID_W      = 16;  // ID field in bits 15..0
  localparam int unsigned CAUSE_LEVEL_LSB = 16;  // Level field starts here

endpackage

`default_nettype wire
